/* conv_engine.f */
design/conv_pkg.sv
design/input_sync.sv
design/conv_unit.sv
design/conv_core.sv
design/output_pipe.sv
design/conv_engine.sv
dv/tb_clock.sv
dv/conv_checker.sv
dv/conv_engine_tb.sv

/* design/conv_core.sv */
module conv_core
    import conv_pkg::*;
#(
    parameter int CONV_UNITS   = 4,
    parameter int KERNEL_W_MAX = 3,
    localparam int N_PIX       = CONV_UNITS + KERNEL_W_MAX - 1
)(
    input  logic                       aclk,
    input  logic                       reset,
    input  logic                       adv,
    input  logic [KW_MAX_BITS-1:0]     kernel_w_1,
    input  logic                       beat_valid,
    input  beat_ctrl_t                 beat_ctrl,
    input  sample_t [N_PIX-1:0]        beat_pixels,
    input  sample_t [KERNEL_W_MAX-1:0] beat_weights,  // this core's taps
    output logic                       res_valid,
    output beat_ctrl_t                 res_ctrl,
    output acc_t [CONV_UNITS-1:0]      res_acc
);

    sample_t [KERNEL_W_MAX-1:0] taps;
    logic [2:0]                 vld_sr;   // product, sum, accumulate
    beat_ctrl_t [2:0]           ctrl_sr;

    // taps past the kernel width, and bubbles, multiply by zero
    always_comb begin
        for (int t = 0; t < KERNEL_W_MAX; t++)
            taps[t] = (beat_valid && t <= kernel_w_1) ? beat_weights[t] : sample_t'('0);
    end

    // ########################################################################
    // valid / ctrl alongside the unit pipelines
    // ########################################################################

    always_ff @(posedge aclk) begin
        if (reset) begin
            vld_sr  <= '0;
            ctrl_sr <= '0;
        end else if (adv) begin
            vld_sr  <= {vld_sr[1:0], beat_valid};
            ctrl_sr <= {ctrl_sr[1:0], beat_ctrl};
        end
    end

    assign res_valid = vld_sr[2];
    assign res_ctrl  = ctrl_sr[2];

    // unit u sees pixels u .. u+KERNEL_W_MAX-1
    for (genvar u = 0; u < CONV_UNITS; u++) begin : g_unit
        conv_unit #(
            .KERNEL_W_MAX (KERNEL_W_MAX)
        ) u_conv_unit (
            .aclk     (aclk),
            .reset    (reset),
            .adv      (adv),
            .pixels   (beat_pixels[u +: KERNEL_W_MAX]),
            .weights  (taps),
            .first_in (ctrl_sr[1].first),
            .acc      (res_acc[u])
        );
    end

endmodule

/* design/conv_engine.sv */
module conv_engine
    import conv_pkg::*;
#(
    parameter int CONV_CORES   = 4,
    parameter int CONV_UNITS   = 4,
    parameter int KERNEL_W_MAX = 3,
    localparam int N_PIX       = CONV_UNITS + KERNEL_W_MAX - 1
)(
    input  logic                                      aclk,
    input  logic                                      reset,
    input  logic                                      start,
    input  cfg_t                                      cfg,
    input  logic                                      s_pixels_valid,
    input  sample_t [N_PIX-1:0]                       s_pixels_data,
    output logic                                      s_pixels_ready,
    input  logic                                      s_weights_valid,
    input  sample_t [CONV_CORES-1:0][KERNEL_W_MAX-1:0] s_weights_data,
    output logic                                      s_weights_ready,
    output logic                                      m_valid,
    output sample_t [CONV_CORES-1:0][CONV_UNITS-1:0]   m_data,
    input  logic                                      m_ready,
    output logic                                      m_last
);

    logic                                      adv;
    logic                                      beat_valid;
    beat_ctrl_t                                beat_ctrl;
    sample_t [N_PIX-1:0]                       beat_pixels;
    sample_t [CONV_CORES-1:0][KERNEL_W_MAX-1:0] beat_weights;
    cfg_t                                      run_cfg;

    logic                                      core_valid [CONV_CORES];
    beat_ctrl_t                                core_ctrl  [CONV_CORES];
    acc_t [CONV_CORES-1:0][CONV_UNITS-1:0]     res_acc;

    // ########################################################################
    // input side
    // ########################################################################

    input_sync #(
        .CONV_CORES   (CONV_CORES),
        .CONV_UNITS   (CONV_UNITS),
        .KERNEL_W_MAX (KERNEL_W_MAX)
    ) u_input_sync (
        .aclk            (aclk),
        .reset           (reset),
        .start           (start),
        .cfg             (cfg),
        .s_pixels_valid  (s_pixels_valid),
        .s_pixels_data   (s_pixels_data),
        .s_pixels_ready  (s_pixels_ready),
        .s_weights_valid (s_weights_valid),
        .s_weights_data  (s_weights_data),
        .s_weights_ready (s_weights_ready),
        .adv             (adv),
        .beat_valid      (beat_valid),
        .beat_ctrl       (beat_ctrl),
        .beat_pixels     (beat_pixels),
        .beat_weights    (beat_weights),
        .run_cfg         (run_cfg)
    );

    // one core per output channel, all sharing the pixel window
    for (genvar c = 0; c < CONV_CORES; c++) begin : g_core
        conv_core #(
            .CONV_UNITS   (CONV_UNITS),
            .KERNEL_W_MAX (KERNEL_W_MAX)
        ) u_conv_core (
            .aclk         (aclk),
            .reset        (reset),
            .adv          (adv),
            .kernel_w_1   (run_cfg.kernel_w_1),
            .beat_valid   (beat_valid),
            .beat_ctrl    (beat_ctrl),
            .beat_pixels  (beat_pixels),
            .beat_weights (beat_weights[c]),
            .res_valid    (core_valid[c]),
            .res_ctrl     (core_ctrl[c]),
            .res_acc      (res_acc[c])
        );
    end

    // ########################################################################
    // output side with flags from core 0
    // ########################################################################

    output_pipe #(
        .CONV_CORES (CONV_CORES),
        .CONV_UNITS (CONV_UNITS)
    ) u_output_pipe (
        .aclk      (aclk),
        .reset     (reset),
        .relu      (run_cfg.relu),
        .res_valid (core_valid[0]),
        .res_ctrl  (core_ctrl[0]),
        .res_acc   (res_acc),
        .m_ready   (m_ready),
        .adv       (adv),
        .m_valid   (m_valid),
        .m_data    (m_data),
        .m_last    (m_last)
    );

endmodule

/* design/conv_pkg.sv */
package conv_pkg;

    // ########################################################################
    // sample and accumulator widths
    // ########################################################################

    localparam int DATA_W     = 16;  // pixel, weight and output sample
    localparam int ACC_W      = 40;  // channel accumulator
    localparam int FRAC_BITS  = 8;   // fixed-point rescale shift

    localparam int KW_MAX_BITS = 2;  // holds kernel_w_1
    localparam int CIN_BITS    = 10;
    localparam int GROUP_BITS  = 10;

    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // saturation bounds at accumulator width
    localparam acc_t SAT_MAX = acc_t'(2**(DATA_W-1) - 1);
    localparam acc_t SAT_MIN = acc_t'(-(2**(DATA_W-1)));

    // ########################################################################
    // control that rides along with every beat
    // ########################################################################

    typedef struct packed {
        logic first;    // clears the accumulator
        logic last;     // releases the group result
        logic run_end;  // last group of the run
    } beat_ctrl_t;

    // run configuration, latched on start
    typedef struct packed {
        logic [KW_MAX_BITS-1:0] kernel_w_1;  // active taps - 1
        logic [CIN_BITS-1:0]    cin_1;       // beats per group - 1
        logic [GROUP_BITS-1:0]  groups_1;    // groups per run - 1
        logic                   relu;
    } cfg_t;

endpackage

/* design/conv_unit.sv */
module conv_unit
    import conv_pkg::*;
#(
    parameter int KERNEL_W_MAX = 3
)(
    input  logic                       aclk,
    input  logic                       reset,
    input  logic                       adv,
    input  sample_t [KERNEL_W_MAX-1:0] pixels,
    input  sample_t [KERNEL_W_MAX-1:0] weights,
    input  logic                       first_in,  // aligned with the tap sum stage
    output acc_t                       acc
);

    localparam int PROD_W = 2 * DATA_W;

    logic signed [PROD_W-1:0] prod_q [KERNEL_W_MAX];
    acc_t                     tap_sum;
    acc_t                     sum_q;
    acc_t                     acc_q;

    // ########################################################################
    // stage 1: one product per tap
    // ########################################################################

    always_ff @(posedge aclk) begin
        if (adv) begin
            for (int t = 0; t < KERNEL_W_MAX; t++)
                prod_q[t] <= pixels[t] * weights[t];
        end
    end

    // ########################################################################
    // stage 2: sum over taps
    // ########################################################################

    always_comb begin
        tap_sum = '0;
        for (int t = 0; t < KERNEL_W_MAX; t++)
            tap_sum = tap_sum + acc_t'(prod_q[t]);  // sign extended
    end

    always_ff @(posedge aclk) begin
        if (adv)
            sum_q <= tap_sum;
    end

    // ########################################################################
    // stage 3: channel accumulator
    // ########################################################################

    always_ff @(posedge aclk) begin
        if (reset)
            acc_q <= '0;
        else if (adv) begin
            if (first_in)
                acc_q <= sum_q;          // new group
            else
                acc_q <= acc_q + sum_q;  // bubbles add zero
        end
    end

    assign acc = acc_q;

endmodule

/* design/input_sync.sv */
module input_sync
    import conv_pkg::*;
#(
    parameter int CONV_CORES   = 4,
    parameter int CONV_UNITS   = 4,
    parameter int KERNEL_W_MAX = 3,
    localparam int N_PIX       = CONV_UNITS + KERNEL_W_MAX - 1
)(
    input  logic                                      aclk,
    input  logic                                      reset,
    input  logic                                      start,
    input  cfg_t                                      cfg,
    input  logic                                      s_pixels_valid,
    input  sample_t [N_PIX-1:0]                       s_pixels_data,
    output logic                                      s_pixels_ready,
    input  logic                                      s_weights_valid,
    input  sample_t [CONV_CORES-1:0][KERNEL_W_MAX-1:0] s_weights_data,
    output logic                                      s_weights_ready,
    input  logic                                      adv,
    output logic                                      beat_valid,
    output beat_ctrl_t                                beat_ctrl,
    output sample_t [N_PIX-1:0]                       beat_pixels,
    output sample_t [CONV_CORES-1:0][KERNEL_W_MAX-1:0] beat_weights,
    output cfg_t                                      run_cfg
);

    logic                  active;
    logic [CIN_BITS-1:0]   beat_cnt;   // beat within group
    logic [GROUP_BITS-1:0] group_cnt;  // group within run
    logic                  accept;
    beat_ctrl_t            tag;

    // ########################################################################
    // pixel / weight join
    // ########################################################################

    assign accept          = adv && active && s_pixels_valid && s_weights_valid;
    assign s_pixels_ready  = adv && active && s_weights_valid;
    assign s_weights_ready = adv && active && s_pixels_valid;

    always_comb begin
        tag.first   = (beat_cnt == '0);
        tag.last    = (beat_cnt == run_cfg.cin_1);
        tag.run_end = tag.last && (group_cnt == run_cfg.groups_1);
    end

    // run state and counters
    always_ff @(posedge aclk) begin
        if (reset) begin
            active    <= 1'b0;
            beat_cnt  <= '0;
            group_cnt <= '0;
            run_cfg   <= '0;
        end else if (start && !active) begin
            active    <= 1'b1;
            beat_cnt  <= '0;
            group_cnt <= '0;
            run_cfg   <= cfg;
        end else if (accept) begin
            if (tag.last) begin
                beat_cnt  <= '0;
                group_cnt <= group_cnt + 1'b1;
                if (tag.run_end)
                    active <= 1'b0;  // readies drop until next start
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // bubbles leave the beat register with no flags
    always_ff @(posedge aclk) begin
        if (reset) begin
            beat_valid <= 1'b0;
            beat_ctrl  <= '0;
        end else if (adv) begin
            beat_valid <= accept;
            beat_ctrl  <= accept ? tag : beat_ctrl_t'('0);
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            beat_pixels  <= s_pixels_data;
            beat_weights <= s_weights_data;
        end
    end

    // once the run completes, nothing is taken until a new start
    a_quiet_after_end: assert property (@(posedge aclk) disable iff (reset)
        accept && tag.run_end |=> (!s_pixels_ready && !s_weights_ready) until start)
        else $error("input accepted after end of run");

    // a mid-run start neither reloads the config nor restarts the counters
    a_start_ignored: assert property (@(posedge aclk) disable iff (reset)
        start && active && !accept
            |=> active && $stable(run_cfg) && $stable(beat_cnt) && $stable(group_cnt))
        else $error("start during an active run changed the run state");

endmodule

/* design/output_pipe.sv */
module output_pipe
    import conv_pkg::*;
#(
    parameter int CONV_CORES = 4,
    parameter int CONV_UNITS = 4
)(
    input  logic                                    aclk,
    input  logic                                    reset,
    input  logic                                    relu,
    input  logic                                    res_valid,
    input  beat_ctrl_t                              res_ctrl,
    input  acc_t [CONV_CORES-1:0][CONV_UNITS-1:0]   res_acc,
    input  logic                                    m_ready,
    output logic                                    adv,
    output logic                                    m_valid,
    output sample_t [CONV_CORES-1:0][CONV_UNITS-1:0] m_data,
    output logic                                    m_last
);

    sample_t [CONV_CORES-1:0][CONV_UNITS-1:0] scaled;
    logic                                     load;

    // relu, arithmetic shift, clamp to sample range
    function automatic sample_t rescale(input acc_t a, input logic relu_en);
        acc_t v;
        v = (relu_en && a < 0) ? acc_t'('0) : a;
        v = v >>> FRAC_BITS;
        if (v > SAT_MAX)
            v = SAT_MAX;
        else if (v < SAT_MIN)
            v = SAT_MIN;
        return sample_t'(v);
    endfunction

    always_comb begin
        for (int c = 0; c < CONV_CORES; c++)
            for (int u = 0; u < CONV_UNITS; u++)
                scaled[c][u] = rescale(res_acc[c][u], relu);
    end

    // ########################################################################
    // held output register
    // ########################################################################

    assign adv  = !m_valid || m_ready;  // empty or draining this cycle
    assign load = res_valid && res_ctrl.last;  // partial sums are dropped

    always_ff @(posedge aclk) begin
        if (reset) begin
            m_valid <= 1'b0;
            m_last  <= 1'b0;
        end else if (adv) begin
            m_valid <= load;
            if (load)
                m_last <= res_ctrl.run_end;
        end
    end

    always_ff @(posedge aclk) begin
        if (adv && load)
            m_data <= scaled;
    end

    a_hold_stable: assert property (@(posedge aclk) disable iff (reset)
        m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last))
        else $error("output changed while stalled");

endmodule

/* dv/conv_checker.sv */
module conv_checker
    import conv_pkg::*;
#(
    parameter int CONV_CORES = 4,
    parameter int CONV_UNITS = 4
)(
    input  logic                                     aclk,
    input  logic                                     reset,
    input  logic                                     m_valid,
    input  logic                                     m_ready,
    input  logic                                     m_last,
    input  sample_t [CONV_CORES-1:0][CONV_UNITS-1:0] m_data,
    input  logic                                     exp_push,
    input  sample_t [CONV_CORES-1:0][CONV_UNITS-1:0] exp_data,
    input  logic                                     exp_last,
    input  logic [7:0]                               exp_test,
    output int                                       mismatches,
    output int                                       unexpected,
    output int                                       pending
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [7:0]                               test;
        logic                                     last;
        sample_t [CONV_CORES-1:0][CONV_UNITS-1:0] data;
    } expect_t;

    expect_t exp_q [$];  // one entry per output group, in order
    expect_t head;

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'd1:    return "basic_conv";
            8'd2:    return "channel_accum";
            8'd3:    return "narrow_kernel_relu";
            8'd4:    return "saturation";
            8'd5:    return "stalls";
            8'd6:    return "run_end";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare_group(input expect_t e);
        for (int c = 0; c < CONV_CORES; c++) begin
            for (int u = 0; u < CONV_UNITS; u++) begin
                if (m_data[c][u] !== e.data[c][u]) begin
                    $display("[ERROR] %s core %0d unit %0d: expected %0d actual %0d",
                             test_name(e.test), c, u, e.data[c][u], m_data[c][u]);
                    mismatches++;
                end
            end
        end
        if (m_last !== e.last) begin
            $display("[ERROR] %s m_last: expected %0b actual %0b",
                     test_name(e.test), e.last, m_last);
            mismatches++;
        end
    endtask

    initial begin
        mismatches = 0;
        unexpected = 0;
        pending    = 0;
    end

    // ########################################################################
    // expected groups in, output transfers compared
    // ########################################################################

    always @(posedge aclk) begin
        if (!reset) begin
            if (exp_push)
                exp_q.push_back('{test: exp_test, last: exp_last, data: exp_data});
            if (m_valid && m_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output with no expected group at time %0t", $time);
                    unexpected++;
                end else begin
                    head = exp_q.pop_front();
                    compare_group(head);
                end
            end
            pending = exp_q.size();
        end
    end

endmodule

/* dv/conv_engine_tb.sv */
module conv_engine_tb
    import conv_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CONV_CORES   = 4;
    localparam int CONV_UNITS   = 4;
    localparam int KERNEL_W_MAX = 3;
    localparam int N_PIX        = CONV_UNITS + KERNEL_W_MAX - 1;

    localparam int TOTAL_BEATS = 8 + 24 + 2 * 6 + 8 + 18 + 4;  // all runs together
    localparam int TIMEOUT     = TOTAL_BEATS * 4 + 200;

    localparam longint OUT_MAX = 2**(DATA_W-1) - 1;
    localparam longint OUT_MIN = -(2**(DATA_W-1));

    localparam int T_BASIC = 1, T_CHANNEL = 2, T_NARROW = 3;
    localparam int T_SAT = 4, T_STALLS = 5, T_RUN_END = 6;
    localparam int MODE_SMALL = 0, MODE_SAT = 1;

    typedef sample_t [N_PIX-1:0]                        pix_t;
    typedef sample_t [CONV_CORES-1:0][KERNEL_W_MAX-1:0] wts_t;
    typedef sample_t [CONV_CORES-1:0][CONV_UNITS-1:0]   out_t;

    logic aclk, reset, start;
    cfg_t cfg;
    logic s_pixels_valid, s_pixels_ready, s_weights_valid, s_weights_ready;
    pix_t s_pixels_data;
    wts_t s_weights_data;
    logic m_valid, m_ready, m_last;
    out_t m_data;

    logic       exp_push, exp_last;
    out_t       exp_data;
    logic [7:0] exp_test;
    int         mismatches, unexpected, pending;

    pix_t        grp_pix [8];  // beats of the group being sent
    wts_t        grp_wts [8];
    logic [31:0] rng_data  = 32'd32736;
    logic [31:0] rng_ready = 32'd32736 ^ 32'h9e3779b9;  // separate stream for m_ready
    logic        ready_stall;
    int          hs_errors;
    int          errors;
    int          cycles = 0;

    tb_clock u_clock (.aclk(aclk), .reset(reset));

    conv_engine #(
        .CONV_CORES   (CONV_CORES),
        .CONV_UNITS   (CONV_UNITS),
        .KERNEL_W_MAX (KERNEL_W_MAX)
    ) u_conv_engine (
        .aclk(aclk), .reset(reset), .start(start), .cfg(cfg),
        .s_pixels_valid(s_pixels_valid), .s_pixels_data(s_pixels_data),
        .s_pixels_ready(s_pixels_ready), .s_weights_valid(s_weights_valid),
        .s_weights_data(s_weights_data), .s_weights_ready(s_weights_ready),
        .m_valid(m_valid), .m_data(m_data), .m_ready(m_ready), .m_last(m_last)
    );

    conv_checker #(
        .CONV_CORES (CONV_CORES),
        .CONV_UNITS (CONV_UNITS)
    ) u_checker (
        .aclk(aclk), .reset(reset), .m_valid(m_valid), .m_ready(m_ready),
        .m_last(m_last), .m_data(m_data), .exp_push(exp_push), .exp_data(exp_data),
        .exp_last(exp_last), .exp_test(exp_test), .mismatches(mismatches),
        .unexpected(unexpected), .pending(pending)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_data = xorshift32(rng_data);
        return rng_data;
    endfunction

    function automatic logic chance(input int pct);
        return (next_rand() % 100) < pct;
    endfunction

    function automatic cfg_t make_cfg(input int kw1, input int cin1, input int groups1,
                                      input logic relu);
        cfg_t c;
        c.kernel_w_1 = KW_MAX_BITS'(kw1);
        c.cin_1      = CIN_BITS'(cin1);
        c.groups_1   = GROUP_BITS'(groups1);
        c.relu       = relu;
        return c;
    endfunction

    // ########################################################################
    // reference model built from the convolution rule
    // ########################################################################

    function automatic out_t ref_group(input int n_beats, input int kw1, input logic relu_en);
        out_t   r;
        longint acc;
        for (int c = 0; c < CONV_CORES; c++) begin
            for (int u = 0; u < CONV_UNITS; u++) begin
                acc = 0;
                for (int b = 0; b < n_beats; b++)
                    for (int t = 0; t <= kw1; t++)  // taps above kw1 are zero
                        acc += longint'(grp_pix[b][u+t]) * longint'(grp_wts[b][c][t]);
                if (relu_en && acc < 0)
                    acc = 0;
                acc = acc >>> FRAC_BITS;
                if (acc > OUT_MAX)
                    acc = OUT_MAX;
                else if (acc < OUT_MIN)
                    acc = OUT_MIN;
                r[c][u] = sample_t'(acc);
            end
        end
        return r;
    endfunction

    task automatic fill_group(input int n_beats, input int mode, input int g);
        logic [31:0] r;
        for (int b = 0; b < n_beats; b++) begin
            for (int p = 0; p < N_PIX; p++) begin
                r = next_rand();
                if (mode == MODE_SAT)
                    grp_pix[b][p] = sample_t'(20000 + r % 12000);
                else
                    grp_pix[b][p] = sample_t'($signed(r[7:0]));
            end
            for (int c = 0; c < CONV_CORES; c++) begin
                for (int t = 0; t < KERNEL_W_MAX; t++) begin
                    r = next_rand();
                    if (mode == MODE_SAT)  // odd groups drive toward the negative clamp
                        grp_wts[b][c][t] = (g % 2) ? -sample_t'(20000 + r % 12000)
                                                   : sample_t'(20000 + r % 12000);
                    else
                        grp_wts[b][c][t] = sample_t'($signed(r[7:0]));
                end
            end
        end
    endtask

    // ########################################################################
    // stimulus tasks called on a falling edge
    // ########################################################################

    task automatic pulse_start(input cfg_t c);
        start = 1'b1;
        cfg   = c;
        @(negedge aclk);
        start = 1'b0;
    endtask

    task automatic push_expected(input out_t e, input logic last, input int id);
        exp_push = 1'b1;
        exp_data = e;
        exp_last = last;
        exp_test = 8'(id);
        @(negedge aclk);
        exp_push = 1'b0;
    endtask

    task automatic send_beat(input pix_t pix, input wts_t wts, input int raise_pct);
        logic pix_xfer;
        logic wts_xfer;
        pix_xfer = 1'b0;
        wts_xfer = 1'b0;
        while (!pix_xfer && !wts_xfer) begin
            if (!s_pixels_valid && chance(raise_pct)) begin
                s_pixels_valid = 1'b1;
                s_pixels_data  = pix;
            end
            if (!s_weights_valid && chance(raise_pct)) begin
                s_weights_valid = 1'b1;
                s_weights_data  = wts;
            end
            #1;
            pix_xfer = s_pixels_valid && s_pixels_ready;
            wts_xfer = s_weights_valid && s_weights_ready;
            if (pix_xfer != wts_xfer) begin  // both streams must move on the same edge
                $display("pixel and weight transfers were not joined at time %0t", $time);
                hs_errors++;
            end
            @(negedge aclk);
        end
        s_pixels_valid  = 1'b0;
        s_weights_valid = 1'b0;
    endtask

    task automatic offer_extra_beats(input int n);
        for (int i = 0; i < n; i++) begin
            s_pixels_valid  = 1'b1;
            s_weights_valid = 1'b1;
            s_pixels_data   = pix_t'(next_rand());
            #1;
            if (s_pixels_ready || s_weights_ready) begin
                $display("input ready raised after the run had ended");
                hs_errors++;
            end
            @(negedge aclk);
        end
        s_pixels_valid  = 1'b0;
        s_weights_valid = 1'b0;
    endtask

    task automatic run_test(input int id, input cfg_t c, input int mode, input int raise_pct);
        int   n_beats;
        out_t e;
        n_beats = int'(c.cin_1) + 1;
        pulse_start(c);
        for (int g = 0; g <= int'(c.groups_1); g++) begin
            fill_group(n_beats, mode, g);
            e = ref_group(n_beats, int'(c.kernel_w_1), c.relu);
            push_expected(e, g == int'(c.groups_1), id);
            for (int b = 0; b < n_beats; b++) begin
                send_beat(grp_pix[b], grp_wts[b], raise_pct);
                if (id == T_RUN_END && g == 0 && b == 0)
                    pulse_start(make_cfg(0, 0, 0, 1'b1));  // ignored mid-run
            end
        end
        if (id == T_RUN_END)
            offer_extra_beats(10);
        while (pending != 0)  // drain before relu or kernel width change
            @(negedge aclk);
    endtask

    always @(negedge aclk) begin
        if (ready_stall) begin
            rng_ready = xorshift32(rng_ready);
            m_ready   = (rng_ready[1:0] != 2'b00);  // low one cycle in four
        end else begin
            m_ready = 1'b1;
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout after %0d cycles, %0d expected groups never produced",
                     cycles, pending);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        start           = 1'b0;
        cfg             = '0;
        s_pixels_valid  = 1'b0;
        s_pixels_data   = '0;
        s_weights_valid = 1'b0;
        s_weights_data  = '0;
        m_ready         = 1'b1;
        exp_push        = 1'b0;
        exp_last        = 1'b0;
        exp_data        = '0;
        exp_test        = '0;
        ready_stall     = 1'b0;
        hs_errors       = 0;
        @(negedge aclk);
        while (reset)
            @(negedge aclk);

        run_test(T_BASIC, make_cfg(2, 0, 7, 1'b0), MODE_SMALL, 100);
        run_test(T_CHANNEL, make_cfg(2, 5, 3, 1'b0), MODE_SMALL, 100);
        run_test(T_NARROW, make_cfg(0, 1, 2, 1'b1), MODE_SMALL, 100);
        run_test(T_NARROW, make_cfg(1, 1, 2, 1'b1), MODE_SMALL, 100);
        run_test(T_SAT, make_cfg(2, 3, 1, 1'b0), MODE_SAT, 100);
        ready_stall = 1'b1;
        run_test(T_STALLS, make_cfg(2, 2, 5, 1'b0), MODE_SMALL, 50);
        ready_stall = 1'b0;
        run_test(T_RUN_END, make_cfg(2, 1, 1, 1'b0), MODE_SMALL, 100);
        repeat (4) @(negedge aclk);

        if (pending != 0)
            $display("%0d expected groups never produced", pending);
        errors = mismatches + unexpected + pending + hs_errors;
        $display("counts: %0d mismatches, %0d unexpected outputs, %0d missing groups, %0d %s",
                 mismatches, unexpected, pending, hs_errors, "handshake errors");
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* dv/tb_clock.sv */
module tb_clock (
    output logic aclk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 8;

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;  // 100 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;  // released on a falling edge
    end

endmodule
